// ==== ad7680_reader.sv ====
module ad7680_reader (
    input  logic                     clk_100m,
    input  logic                     rst,
    input  logic                     adc_rd,
    output logic                     adc_busy,
    output logic                     cs_n,
    output logic                     sclk,
    input  logic                     sdata,
    output dev_data_pkg::adc_sample_t sample,
    output logic                     sample_valid,
    output dev_data_pkg::adc_sample_t sample_lock
);

    import dev_data_pkg::*;
    import spi_timing_pkg::*;

    logic [ad7680_frame_bits-1:0] rx_frame;
    logic                         frame_done;
    adc_sample_t                  rx_sample;

    spi_frame_engine #(
        .frame_bits (ad7680_frame_bits),
        .half_div   (ad7680_half_div)
    ) i_spi_frame_engine (
        .clk_100m   (clk_100m),
        .rst        (rst),
        .start      (adc_rd),
        .tx_frame   ('0),                               // ADC is read only
        .rx_frame   (rx_frame),
        .busy       (adc_busy),
        .done       (frame_done),
        .cs_n       (cs_n),
        .sclk       (sclk),
        .mosi       (),
        .miso       (sdata)
    );

    // --------------------------------------------------
    // sample extraction
    // --------------------------------------------------

    // skip the leading zeros, trailing zeros fall off the bottom
    assign rx_sample = rx_frame[ad7680_frame_bits-1-$bits(ad7680_lead_zeros) -:
                                $bits(adc_sample_t)];

    always_ff @(posedge clk_100m or posedge rst) begin
        if (rst) begin
            sample_valid <= 1'b0;
            sample_lock <= '0;
        end else begin
            sample_valid <= frame_done;                 // one cycle after done
            if (frame_done) begin
                sample_lock <= rx_sample;               // held until next read
            end
        end
    end

    always_ff @(posedge clk_100m) begin
        if (frame_done) begin
            sample <= rx_sample;                        // qualified by sample_valid
        end
    end

endmodule

// ==== dev_data_pkg.sv ====
package dev_data_pkg;

    // --------------------------------------------------
    // payload types
    // --------------------------------------------------

    typedef logic [15:0] dac_code_t;                // MAX5216 output code
    typedef logic [15:0] adc_sample_t;              // AD7680 conversion result

    // --------------------------------------------------
    // MAX5216 frame format
    // --------------------------------------------------

    // The DAC frame is 24 bits, MSB first:
    //   [23:22] control field, 01 loads and updates the output
    //   [21:6]  output code
    //   [5:0]   don't care, sent as zeros
    localparam logic [1:0] max5216_cmd_write = 2'b01;   // write-through command
    localparam logic [5:0] max5216_pad_bits = 6'b0;     // frame tail

    // --------------------------------------------------
    // AD7680 frame format
    // --------------------------------------------------

    // The ADC frame is 24 clocks: four leading zeros, the 16-bit
    // sample MSB first, then four trailing zeros
    localparam logic [3:0] ad7680_lead_zeros = 4'b0;    // zeros before sample msb

endpackage

// ==== max5216_writer.sv ====
module max5216_writer (
    input  logic                   clk_100m,
    input  logic                   rst,
    input  logic                   dac_wr,
    input  dev_data_pkg::dac_code_t dac_code,
    output logic                   dac_busy,
    output logic                   cs_n,
    output logic                   sclk,
    output logic                   din,
    output logic                   clr_n
);

    import dev_data_pkg::*;
    import spi_timing_pkg::*;

    logic [max5216_frame_bits-1:0] dac_frame;

    // --------------------------------------------------
    // frame assembly
    // --------------------------------------------------

    // The engine latches the frame on the accepted strobe, so the code
    // may change right after dac_wr
    assign dac_frame = {max5216_cmd_write, dac_code, max5216_pad_bits};

    spi_frame_engine #(
        .frame_bits (max5216_frame_bits),
        .half_div   (max5216_half_div)
    ) i_spi_frame_engine (
        .clk_100m   (clk_100m),
        .rst        (rst),
        .start      (dac_wr),           // engine drops it when busy
        .tx_frame   (dac_frame),
        .rx_frame   (),                 // DAC has no readback line
        .busy       (dac_busy),
        .done       (),
        .cs_n       (cs_n),
        .sclk       (sclk),
        .mosi       (din),
        .miso       (1'b0)
    );

    // --------------------------------------------------
    // clear line
    // --------------------------------------------------

    // DAC output held at zero scale while the board is in reset
    always_ff @(posedge clk_100m or posedge rst) begin
        if (rst) begin
            clr_n <= 1'b0;
        end else begin
            clr_n <= 1'b1;                  // released on first clock after rst
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# compile with Verilator, run, and pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_slow_device -f slow_device.f || exit 1
out="$(./obj_dir/Vtb_slow_device)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "Done: no errors" && echo "simulation passed" || {
    echo "simulation failed"
    exit 1
}

// ==== slow_device.f ====
spi_timing_pkg.sv
dev_data_pkg.sv
spi_frame_engine.sv
max5216_writer.sv
ad7680_reader.sv
slow_device_top.sv
tb_clock_gen.sv
tb_spi_models.sv
tb_slow_device.sv

// ==== slow_device_top.sv ====
module slow_device_top (
    input  logic                      clk_100m,
    input  logic                      rst,
    // MAX5216 DAC
    input  logic                      dac_wr,
    input  dev_data_pkg::dac_code_t   dac_code,
    output logic                      dac_busy,
    output logic                      max5216_cs_n,
    output logic                      max5216_sclk,
    output logic                      max5216_din,
    output logic                      max5216_clr_n,
    // AD7680 ADC
    input  logic                      adc_rd,
    output logic                      adc_busy,
    output logic                      ad7680_cs_n,
    output logic                      ad7680_sclk,
    input  logic                      ad7680_data,
    output dev_data_pkg::adc_sample_t adc_sample,
    output logic                      adc_sample_valid,
    output dev_data_pkg::adc_sample_t adc_sample_lock
);

    // --------------------------------------------------
    // device drivers, fully independent
    // --------------------------------------------------

    max5216_writer i_max5216_writer (
        .clk_100m     (clk_100m),
        .rst          (rst),
        .dac_wr       (dac_wr),
        .dac_code     (dac_code),
        .dac_busy     (dac_busy),
        .cs_n         (max5216_cs_n),
        .sclk         (max5216_sclk),       // 25 MHz
        .din          (max5216_din),
        .clr_n        (max5216_clr_n)
    );

    ad7680_reader i_ad7680_reader (
        .clk_100m     (clk_100m),
        .rst          (rst),
        .adc_rd       (adc_rd),
        .adc_busy     (adc_busy),
        .cs_n         (ad7680_cs_n),
        .sclk         (ad7680_sclk),        // 2.5 MHz
        .sdata        (ad7680_data),
        .sample       (adc_sample),
        .sample_valid (adc_sample_valid),
        .sample_lock  (adc_sample_lock)
    );

endmodule

// ==== spi_frame_engine.sv ====
module spi_frame_engine #(
    parameter int frame_bits = 24,
    parameter int half_div = 2
) (
    input  logic                  clk_100m,
    input  logic                  rst,
    input  logic                  start,
    input  logic [frame_bits-1:0] tx_frame,
    output logic [frame_bits-1:0] rx_frame,
    output logic                  busy,
    output logic                  done,
    output logic                  cs_n,
    output logic                  sclk,
    output logic                  mosi,
    input  logic                  miso
);

    localparam int hc_w = $clog2(half_div + 1);
    localparam int bc_w = $clog2(frame_bits + 1);
    localparam logic [hc_w-1:0] half_last = hc_w'(half_div - 1);
    localparam logic [bc_w-1:0] bit_last = bc_w'(frame_bits - 1);

    logic [hc_w-1:0]       half_cnt;        // cycles within one sclk phase
    logic [bc_w-1:0]       bit_cnt;         // bit being sent
    logic                  tail;            // last rising edge seen, cs still low
    logic                  take;
    logic                  half_end;
    logic                  sclk_rise;
    logic [frame_bits-1:0] tx_shift;
    logic [frame_bits-1:0] rx_shift;

    assign take = start && !busy;                               // strobes while busy are lost
    assign half_end = busy && !tail && (half_cnt == half_last);
    assign sclk_rise = half_end && !sclk;                       // bit boundary

    // --------------------------------------------------
    // frame sequencing
    // --------------------------------------------------

    // A frame is cs fall with sclk high, then per bit one high phase and
    // one low phase of half_div cycles each. The rising edge that closes
    // the last bit leaves one more cycle with cs low before cs rises.
    always_ff @(posedge clk_100m or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            cs_n <= 1'b1;
            sclk <= 1'b1;                   // idles high
            tail <= 1'b0;
            half_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            done <= 1'b0;
            if (take) begin
                busy <= 1'b1;
                cs_n <= 1'b0;
                sclk <= 1'b1;
                tail <= 1'b0;
                half_cnt <= '0;
                bit_cnt <= '0;
            end else if (busy && tail) begin
                busy <= 1'b0;
                cs_n <= 1'b1;
                done <= 1'b1;               // rx_frame valid here
                tail <= 1'b0;
            end else if (half_end) begin
                half_cnt <= '0;
                if (sclk) begin
                    sclk <= 1'b0;           // device samples mosi here
                end else begin
                    sclk <= 1'b1;
                    if (bit_cnt == bit_last) begin
                        tail <= 1'b1;
                    end else begin
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
            end else if (busy) begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // data shift registers
    // --------------------------------------------------

    always_ff @(posedge clk_100m) begin
        if (take) begin
            tx_shift <= tx_frame;                               // msb on the pin next cycle
        end else if (sclk_rise) begin
            tx_shift <= {tx_shift[frame_bits-2:0], 1'b0};
            rx_shift <= {rx_shift[frame_bits-2:0], miso};       // miso settled since fall
        end
    end

    assign mosi = tx_shift[frame_bits-1];
    assign rx_frame = rx_shift;

endmodule

// ==== spi_timing_pkg.sv ====
package spi_timing_pkg;

    // --------------------------------------------------
    // MAX5216 DAC serial timing
    // --------------------------------------------------

    // cmd + code + pad, one frame per write
    localparam int max5216_frame_bits = 24;

    // 100 MHz / (2 * 2) gives a 25 MHz serial clock
    localparam int max5216_half_div = 2;

    // --------------------------------------------------
    // AD7680 ADC serial timing
    // --------------------------------------------------

    // lead zeros + sample + trailing zeros
    localparam int ad7680_frame_bits = 24;

    // 100 MHz / (2 * 20) gives a 2.5 MHz serial clock
    localparam int ad7680_half_div = 20;

endpackage

// ==== tb_clock_gen.sv ====
module tb_clock_gen (
    output logic clk_100m,
    output logic rst
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period_ns = 5;      // 10 ns period
    localparam int reset_cycles = 4;

    initial begin
        clk_100m = 1'b0;
        forever #half_period_ns clk_100m = ~clk_100m;
    end

    initial begin
        rst <= 1'b1;
        repeat (reset_cycles) @(posedge clk_100m);
        rst <= 1'b0;                        // flops still see rst on this edge
    end

endmodule

// ==== tb_slow_device.sv ====
module tb_slow_device;

    timeunit 1ns;
    timeprecision 100ps;

    import spi_timing_pkg::*;
    import dev_data_pkg::*;

    // strobe to cs_n high, and strobe to valid pulse
    localparam int dac_latency = max5216_frame_bits * 2 * max5216_half_div + 2;
    localparam int adc_latency = ad7680_frame_bits * 2 * ad7680_half_div + 3;
    localparam int watchdog_ns = (20 * adc_latency + 40 * dac_latency) * 2 * 10;

    logic clk_100m;
    logic rst;
    logic dac_wr;
    dac_code_t dac_code;
    logic dac_busy;
    logic max5216_cs_n;
    logic max5216_sclk;
    logic max5216_din;
    logic max5216_clr_n;
    logic adc_rd;
    logic adc_busy;
    logic ad7680_cs_n;
    logic ad7680_sclk;
    logic ad7680_data;
    adc_sample_t adc_sample;
    logic adc_sample_valid;
    adc_sample_t adc_sample_lock;
    logic [max5216_frame_bits-1:0] dac_frame;
    int dac_frames;
    logic [ad7680_frame_bits-1:0] adc_pattern;

    int errors;
    int checks;
    logic [31:0] lcg_state;
    adc_sample_t last_sample;               // what the lock should hold

    tb_clock_gen i_tb_clock_gen (
        .clk_100m (clk_100m),
        .rst      (rst)
    );

    slow_device_top i_slow_device_top (
        .clk_100m         (clk_100m),
        .rst              (rst),
        .dac_wr           (dac_wr),
        .dac_code         (dac_code),
        .dac_busy         (dac_busy),
        .max5216_cs_n     (max5216_cs_n),
        .max5216_sclk     (max5216_sclk),
        .max5216_din      (max5216_din),
        .max5216_clr_n    (max5216_clr_n),
        .adc_rd           (adc_rd),
        .adc_busy         (adc_busy),
        .ad7680_cs_n      (ad7680_cs_n),
        .ad7680_sclk      (ad7680_sclk),
        .ad7680_data      (ad7680_data),
        .adc_sample       (adc_sample),
        .adc_sample_valid (adc_sample_valid),
        .adc_sample_lock  (adc_sample_lock)
    );

    tb_spi_models i_tb_spi_models (
        .max5216_cs_n (max5216_cs_n),
        .max5216_sclk (max5216_sclk),
        .max5216_din  (max5216_din),
        .dac_frame    (dac_frame),
        .dac_frames   (dac_frames),
        .ad7680_cs_n  (ad7680_cs_n),
        .ad7680_sclk  (ad7680_sclk),
        .ad7680_data  (ad7680_data),
        .adc_pattern  (adc_pattern)
    );

    // --------------------------------------------------
    // helpers and compare tasks
    // --------------------------------------------------

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic next_cycle();
        @(posedge clk_100m);
        #1;                                 // drive and sample point
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_dac_code(input string name, input dac_code_t got, input dac_code_t exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%04h expected 0x%04h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_adc_sample(input string name, input adc_sample_t got,
                                    input adc_sample_t exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%04h expected 0x%04h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_dac_frame(input string name, input logic [23:0] got,
                                   input logic [23:0] exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s got 0x%06h expected 0x%06h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            $display("MISMATCH %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // steps until cs_n is back high, counting cycles from the strobe;
    // busy is expected high for the first busy_cycles - 1 cycles
    task automatic wait_dac_frame(input int busy_cycles, output int cycles);
        cycles = 0;
        do begin
            next_cycle();
            cycles++;
            dac_wr = 1'b0;
            check_bit("dac_busy", dac_busy, cycles < busy_cycles);
        end while (!max5216_cs_n && cycles < 2 * dac_latency);
        if (!max5216_cs_n) begin
            $display("ERROR: DAC chip select still low %0d cycles after the strobe", cycles);
            errors++;
        end
    endtask

    task automatic run_dac_write(input dac_code_t code);
        int cycles;
        int frames_before;
        frames_before = dac_frames;
        dac_code = code;
        dac_wr = 1'b1;
        wait_dac_frame(dac_latency, cycles);
        check_count("max5216_cs_n rise cycles", cycles, dac_latency);
        check_dac_frame("max5216 frame", dac_frame, {2'b01, code, 6'b000000});
        check_count("max5216 frame count", dac_frames, frames_before + 1);
        check_bit("dac_busy", dac_busy, 1'b0);
    endtask

    task automatic run_adc_read(input adc_sample_t sample);
        int cycles;
        logic lock_moved;
        lock_moved = 1'b0;
        check_adc_sample("adc_sample_lock before read", adc_sample_lock, last_sample);
        adc_pattern = {4'h0, sample, 4'h0};
        adc_rd = 1'b1;
        cycles = 0;
        do begin
            next_cycle();
            cycles++;
            adc_rd = 1'b0;
            check_bit("adc_busy", adc_busy, cycles < adc_latency - 1);  // drops with done
            if (!adc_sample_valid && adc_sample_lock !== last_sample) lock_moved = 1'b1;
        end while (!adc_sample_valid && cycles < 2 * adc_latency);
        if (lock_moved) begin
            $display("ERROR: adc_sample_lock changed before adc_sample_valid");
            errors++;
        end
        check_count("adc_sample_valid cycles", cycles, adc_latency);
        check_adc_sample("adc_sample", adc_sample, sample);
        check_adc_sample("adc_sample_lock", adc_sample_lock, sample);
        next_cycle();
        check_bit("adc_sample_valid", adc_sample_valid, 1'b0);  // one cycle only
        check_bit("adc_busy", adc_busy, 1'b0);
        last_sample = sample;
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------

    task automatic test_reset_state();
        next_cycle();
        check_bit("max5216_clr_n in reset", max5216_clr_n, 1'b0);
        while (rst) next_cycle();
        next_cycle();
        check_bit("max5216_cs_n", max5216_cs_n, 1'b1);
        check_bit("max5216_sclk", max5216_sclk, 1'b1);
        check_bit("ad7680_cs_n", ad7680_cs_n, 1'b1);
        check_bit("ad7680_sclk", ad7680_sclk, 1'b1);
        check_bit("dac_busy", dac_busy, 1'b0);
        check_bit("adc_busy", adc_busy, 1'b0);
        check_bit("adc_sample_valid", adc_sample_valid, 1'b0);
        check_adc_sample("adc_sample_lock", adc_sample_lock, 16'h0000);
        check_bit("max5216_clr_n", max5216_clr_n, 1'b1);
    endtask

    task automatic test_dac_write();
        logic [31:0] rnd;
        repeat (6) begin
            rnd = lcg_next();
            run_dac_write(rnd[31:16]);
            repeat (3) next_cycle();
        end
    endtask

    task automatic test_adc_read();
        logic [31:0] rnd;
        repeat (3) begin
            rnd = lcg_next();
            run_adc_read(rnd[23:8]);
            repeat (20) next_cycle();       // lock must hold while idle
        end
    endtask

    task automatic test_busy_strobes();
        logic [31:0] rnd;
        dac_code_t first_code;
        adc_sample_t sample;
        int cycles;
        int frames_before;
        int valids;
        int first_valid;
        rnd = lcg_next();
        first_code = rnd[31:16];
        frames_before = dac_frames;
        dac_code = first_code;
        dac_wr = 1'b1;
        repeat (10) begin
            next_cycle();
            dac_wr = 1'b0;
        end
        dac_code = ~first_code;
        dac_wr = 1'b1;                      // lands mid frame
        wait_dac_frame(dac_latency - 10, cycles);
        check_count("max5216_cs_n rise cycles after second strobe", cycles, dac_latency - 10);
        repeat (dac_latency) next_cycle();
        check_count("max5216 frame count", dac_frames, frames_before + 1);
        check_dac_code("max5216 frame code", dac_frame[21:6], first_code);

        rnd = lcg_next();
        sample = rnd[23:8];
        adc_pattern = {4'h0, sample, 4'h0};
        adc_rd = 1'b1;
        valids = 0;
        first_valid = 0;
        for (cycles = 1; cycles <= 2 * adc_latency; cycles++) begin
            next_cycle();
            adc_rd = (cycles == 100);
            if (adc_sample_valid) begin
                valids++;
                if (first_valid == 0) first_valid = cycles;
            end
        end
        check_count("adc_sample_valid pulses", valids, 1);
        check_count("adc_sample_valid cycles", first_valid, adc_latency);
        check_adc_sample("adc_sample_lock", adc_sample_lock, sample);
        last_sample = sample;
    endtask

    task automatic test_parallel_devices();
        logic [31:0] rnd;
        dac_code_t code;
        adc_sample_t sample;
        int cycles;
        int dac_cycles;
        int adc_cycles;
        int frames_before;
        repeat (2) begin
            rnd = lcg_next();
            code = rnd[31:16];
            sample = rnd[15:0];
            frames_before = dac_frames;
            adc_pattern = {4'h0, sample, 4'h0};
            dac_code = code;
            dac_wr = 1'b1;
            adc_rd = 1'b1;
            cycles = 0;
            dac_cycles = 0;
            adc_cycles = 0;
            while ((dac_cycles == 0 || adc_cycles == 0) && cycles < 2 * adc_latency) begin
                next_cycle();
                cycles++;
                dac_wr = 1'b0;
                adc_rd = 1'b0;
                if (dac_cycles == 0 && max5216_cs_n) dac_cycles = cycles;
                if (adc_cycles == 0 && adc_sample_valid) adc_cycles = cycles;
            end
            check_count("max5216_cs_n rise cycles", dac_cycles, dac_latency);
            check_count("adc_sample_valid cycles", adc_cycles, adc_latency);
            check_adc_sample("adc_sample", adc_sample, sample);
            check_dac_frame("max5216 frame", dac_frame, {2'b01, code, 6'b000000});
            check_count("max5216 frame count", dac_frames, frames_before + 1);
            next_cycle();
            last_sample = sample;
        end
    endtask

    // --------------------------------------------------
    // main sequence and watchdog
    // --------------------------------------------------

    initial begin
        errors = 0;
        checks = 0;
        lcg_state = 32'h509a;
        last_sample = '0;
        dac_wr = 1'b0;
        dac_code = '0;
        adc_rd = 1'b0;
        adc_pattern = '0;
        test_reset_state();
        test_dac_write();
        test_adc_read();
        test_busy_strobes();
        test_parallel_devices();
        repeat (5) next_cycle();
        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("TIMEOUT: simulation still running after %0d ns", watchdog_ns);
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== tb_spi_models.sv ====
module tb_spi_models (
    // MAX5216 receiver
    input  logic                                      max5216_cs_n,
    input  logic                                      max5216_sclk,
    input  logic                                      max5216_din,
    output logic [spi_timing_pkg::max5216_frame_bits-1:0] dac_frame,
    output int                                        dac_frames,
    // AD7680 sample source
    input  logic                                      ad7680_cs_n,
    input  logic                                      ad7680_sclk,
    output logic                                      ad7680_data,
    input  logic [spi_timing_pkg::ad7680_frame_bits-1:0] adc_pattern
);

    timeunit 1ns;
    timeprecision 100ps;

    import spi_timing_pkg::*;

    logic [max5216_frame_bits-1:0] dac_shift;
    int                            dac_bits;
    logic [ad7680_frame_bits-1:0]  adc_shift;

    initial begin
        dac_frame = '0;
        dac_frames = 0;
        dac_shift = '0;
        dac_bits = 0;
        adc_shift = '0;
        ad7680_data = 1'b0;
    end

    // --------------------------------------------------
    // MAX5216 receiver
    // --------------------------------------------------

    // din is taken on falling sclk, the frame closes on cs_n rise
    always @(negedge max5216_sclk or posedge max5216_cs_n) begin
        if (max5216_cs_n) begin
            if (dac_bits > 0) begin                         // skip the reset edge
                dac_frame = dac_shift;
                dac_frames++;
            end
            dac_bits = 0;
        end else begin
            dac_shift = {dac_shift[max5216_frame_bits-2:0], max5216_din};
            dac_bits++;
        end
    end

    // --------------------------------------------------
    // AD7680 sample source
    // --------------------------------------------------

    // sclk is high at cs_n fall, so that edge loads the pattern;
    // each falling sclk then puts the next bit on the line
    always @(negedge ad7680_cs_n or negedge ad7680_sclk) begin
        if (ad7680_sclk) begin
            adc_shift = adc_pattern;
            ad7680_data <= 1'b0;
        end else if (!ad7680_cs_n) begin
            ad7680_data <= adc_shift[ad7680_frame_bits-1];
            adc_shift = {adc_shift[ad7680_frame_bits-2:0], 1'b0};
        end
    end

endmodule
